//--- fwd_arb_pkg.sv
package fwd_arb_pkg;

   // Build configuration
   localparam int N_SRC  = 8;
   localparam int DATA_W = 32;
   localparam int SRC_W  = $clog2(N_SRC);

   // Leaf count rounded up to 3k+1 so every internal node has exactly four inputs
   localparam int PADDED    = (N_SRC % 3 == 1) ? N_SRC :
                              ((N_SRC % 3 == 0) ? N_SRC + 1 : N_SRC + 2);
   localparam int TREE_H    = ($clog2(PADDED) + 1) / 2;
   localparam int TAG_W     = 2 * TREE_H;
   localparam int N_INNER   = (PADDED - 1) / 3;
   localparam int NUM_NODES = PADDED + N_INNER;

   // Nodes sitting on the deepest level of the tree
   localparam int N_DEEP = NUM_NODES - (4 ** TREE_H - 1) / 3;
   // Sources below this index take the long path, the rest get a delay stage
   localparam int N_LONG = (N_SRC < N_DEEP) ? N_SRC : N_DEEP;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [SRC_W-1:0]  src_t;
   typedef logic [TAG_W-1:0]  tag_t;
   typedef logic [N_SRC-1:0]  req_t;

   typedef struct packed {
      logic valid;
      src_t src;
      tag_t tag;
   } grant_s;

   // Level counted up from the leaf level; only meaningful for internal nodes
   function automatic int node_level(int node);
      int k;
      int depth;
      k = node;
      depth = 0;
      for (int step = 0; step < TREE_H; step++) begin
         if (k != NUM_NODES - 1) begin
            k = PADDED + k / 4;
            depth++;
         end
      end
      return TREE_H - 1 - depth;
   endfunction

   // Walk from a leaf up to the root, dropping each branch digit at its level
   function automatic tag_t src_to_tag(src_t src);
      tag_t tag;
      int   k;
      int   parent;
      tag = '0;
      k = int'(src);
      for (int step = 0; step < TREE_H; step++) begin
         if (k != NUM_NODES - 1) begin
            parent = PADDED + k / 4;
            tag[2 * node_level(parent) +: 2] = 2'(k % 4);
            k = parent;
         end
      end
      return tag;
   endfunction

   // Inverse walk, from the root down to the leaf a tag routes to
   function automatic int tag_to_leaf(tag_t tag);
      int k;
      k = NUM_NODES - 1;
      for (int step = 0; step < TREE_H; step++) begin
         if (k >= PADDED) begin
            k = 4 * (k - PADDED) + int'(tag[2 * node_level(k) +: 2]);
         end
      end
      return k;
   endfunction

endpackage

//--- mux_tree_node.sv
`timescale 1ns/100ps

module mux_tree_node #(
   parameter bit ENABLE_DELAY = 1'b1
) (
   input  logic               clk,
   input  logic               rst,
   input  logic [1:0]         sel,
   input  fwd_arb_pkg::data_t a,
   input  fwd_arb_pkg::data_t b,
   input  fwd_arb_pkg::data_t c,
   input  fwd_arb_pkg::data_t d,
   output fwd_arb_pkg::data_t result
);

   fwd_arb_pkg::data_t chosen;

   always_comb begin
      case (sel)
         2'd0:    chosen = a;
         2'd1:    chosen = b;
         2'd2:    chosen = c;
         default: chosen = d;
      endcase
   end

   if (ENABLE_DELAY) begin : g_reg
      fwd_arb_pkg::data_t chosen_q;

      always_ff @(posedge clk) begin
         if (rst) begin
            chosen_q <= '0;
         end else begin
            chosen_q <= chosen;
         end
      end

      assign result = chosen_q;
   end else begin : g_comb
      // Pure mux, no pipeline stage at this node
      assign result = chosen;
   end

endmodule

//--- mux_tree.sv
`timescale 1ns/100ps

module mux_tree (
   input  logic                                   clk,
   input  logic                                   rst,
   input  fwd_arb_pkg::tag_t                      sel,
   input  fwd_arb_pkg::data_t [fwd_arb_pkg::N_SRC-1:0] ins,
   output fwd_arb_pkg::data_t                     result
);

   // Leaves first, then internal nodes, root in the last slot
   wire fwd_arb_pkg::data_t nodes [fwd_arb_pkg::NUM_NODES];

   // sel_pipe[j] holds the tag issued j+1 cycles ago
   fwd_arb_pkg::tag_t sel_pipe [fwd_arb_pkg::TREE_H-1];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int j = 0; j < fwd_arb_pkg::TREE_H - 1; j++) begin
            sel_pipe[j] <= '0;
         end
      end else begin
         sel_pipe[0] <= sel;
         for (int j = 1; j < fwd_arb_pkg::TREE_H - 1; j++) begin
            sel_pipe[j] <= sel_pipe[j-1];
         end
      end
   end

   for (genvar i = 0; i < fwd_arb_pkg::PADDED; i++) begin : g_leaf
      if (i < fwd_arb_pkg::N_LONG) begin : g_long
         assign nodes[i] = ins[i];
      end else if (i < fwd_arb_pkg::N_SRC) begin : g_short
         // One level shallower, so hold the word one cycle to even out the paths
         fwd_arb_pkg::data_t leaf_q;

         always_ff @(posedge clk) begin
            if (rst) begin
               leaf_q <= '0;
            end else begin
               leaf_q <= ins[i];
            end
         end

         assign nodes[i] = leaf_q;
      end else begin : g_pad
         assign nodes[i] = '0;
      end
   end

   for (genvar i = 0; i < fwd_arb_pkg::N_INNER; i++) begin : g_node
      logic [1:0] node_sel;

      if (fwd_arb_pkg::node_level(fwd_arb_pkg::PADDED + i) == 0) begin : g_leaf_level
         // Leaf level uses the low digit of the fresh tag
         assign node_sel = sel[1:0];
      end else begin : g_upper_level
         // Higher levels see the tag as old as their distance from the leaves
         assign node_sel =
            sel_pipe[fwd_arb_pkg::node_level(fwd_arb_pkg::PADDED + i) - 1]
                    [2 * fwd_arb_pkg::node_level(fwd_arb_pkg::PADDED + i) +: 2];
      end

      mux_tree_node #(
         .ENABLE_DELAY(1'b1)
      ) u_node (
         .clk    (clk),
         .rst    (rst),
         .sel    (node_sel),
         .a      (nodes[4*i]),
         .b      (nodes[4*i+1]),
         .c      (nodes[4*i+2]),
         .d      (nodes[4*i+3]),
         .result (nodes[fwd_arb_pkg::PADDED + i])
      );
   end

   assign result = nodes[fwd_arb_pkg::NUM_NODES - 1];

   // Tags from the arbiter must always land on a real source, never on a pad leaf
   a_tag_hits_source: assert property (
      @(posedge clk) disable iff (rst)
      fwd_arb_pkg::tag_to_leaf(sel) < fwd_arb_pkg::N_SRC
   ) else $error("tree tag %h routes to padding leaf %0d of %0d nodes",
                 sel, fwd_arb_pkg::tag_to_leaf(sel), fwd_arb_pkg::NUM_NODES);

endmodule

//--- rr_arbiter.sv
`timescale 1ns/100ps

module rr_arbiter (
   input  logic                clk,
   input  logic                rst,
   input  fwd_arb_pkg::req_t   req,
   output fwd_arb_pkg::req_t   grant,
   output fwd_arb_pkg::grant_s dec
);

   // Highest priority source for the current cycle
   fwd_arb_pkg::src_t ptr;
   fwd_arb_pkg::src_t winner;
   logic              found;

   // Constant tag table indexed by source
   fwd_arb_pkg::tag_t tag_lut [fwd_arb_pkg::N_SRC];

   always_comb begin
      for (int s = 0; s < fwd_arb_pkg::N_SRC; s++) begin
         tag_lut[s] = fwd_arb_pkg::src_to_tag(fwd_arb_pkg::src_t'(s));
      end
   end

   // Scan upward from the pointer with wraparound so the first requester wins
   always_comb begin
      int idx;
      found  = 1'b0;
      winner = '0;
      for (int k = 0; k < fwd_arb_pkg::N_SRC; k++) begin
         idx = (int'(ptr) + k) % fwd_arb_pkg::N_SRC;
         if (!found && req[idx]) begin
            found  = 1'b1;
            winner = fwd_arb_pkg::src_t'(idx);
         end
      end
   end

   always_comb begin
      if (found) begin
         grant = fwd_arb_pkg::req_t'(1) << winner;
      end else begin
         grant = '0;
      end
   end

   // Idle cycles still carry source 0's tag so the tree never points at padding
   assign dec.valid = found;
   assign dec.src   = winner;
   assign dec.tag   = tag_lut[winner];

   always_ff @(posedge clk) begin
      if (rst) begin
         ptr <= '0;
      end else if (found) begin
         if (winner == fwd_arb_pkg::src_t'(fwd_arb_pkg::N_SRC - 1)) begin
            ptr <= '0;
         end else begin
            ptr <= winner + 1'b1;
         end
      end
   end

   // Grant only goes to a requester, and only when someone asks
   a_grant_consistent: assert property (
      @(posedge clk) disable iff (rst)
      $onehot0(grant) && ((grant & ~req) == '0) &&
      (dec.valid == (req != '0)) && (!dec.valid || grant[dec.src])
   ) else $error("grant %h disagrees with request %h, decode valid %b src %0d",
                 grant, req, dec.valid, dec.src);

   // A granted source only wins again next cycle if nobody else asks
   a_fair_turn: assert property (
      @(posedge clk) disable iff (rst)
      dec.valid ##1 dec.valid && ($past(dec.src) == dec.src) |->
         (req == fwd_arb_pkg::req_t'(1) << dec.src)
   ) else $error("source %0d granted twice while others waited", dec.src);

endmodule

//--- fwd_result.sv
`timescale 1ns/100ps

module fwd_result (
   input  logic               clk,
   input  logic               rst,
   input  logic               dec_valid,
   input  fwd_arb_pkg::src_t  dec_src,
   input  fwd_arb_pkg::data_t tree_data,
   output logic               out_valid,
   output fwd_arb_pkg::src_t  out_src,
   output fwd_arb_pkg::data_t out_data
);

   // Matches the tree depth stage for stage
   logic [fwd_arb_pkg::TREE_H-1:0] valid_q;
   fwd_arb_pkg::src_t              src_q [fwd_arb_pkg::TREE_H];

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         for (int j = 0; j < fwd_arb_pkg::TREE_H; j++) begin
            src_q[j] <= '0;
         end
      end else begin
         valid_q[0] <= dec_valid;
         src_q[0]   <= dec_src;
         for (int j = 1; j < fwd_arb_pkg::TREE_H; j++) begin
            valid_q[j] <= valid_q[j-1];
            src_q[j]   <= src_q[j-1];
         end
      end
   end

   assign out_valid = valid_q[fwd_arb_pkg::TREE_H-1];
   assign out_src   = src_q[fwd_arb_pkg::TREE_H-1];

   // Tree output is only meaningful alongside an aligned valid
   assign out_data = out_valid ? tree_data : '0;

   a_out_src_aligned: assert property (
      @(posedge clk) disable iff (rst)
      out_valid |-> (out_src < fwd_arb_pkg::N_SRC) &&
                    $past(dec_valid, fwd_arb_pkg::TREE_H) &&
                    (out_src == $past(dec_src, fwd_arb_pkg::TREE_H))
   ) else $error("out_src %0d not aligned with its grant", out_src);

endmodule

//--- fwd_arb_top.sv
`timescale 1ns/100ps

module fwd_arb_top (
   input  logic                                   clk,
   input  logic                                   rst,
   input  fwd_arb_pkg::req_t                      req,
   input  fwd_arb_pkg::data_t [fwd_arb_pkg::N_SRC-1:0] in_data,
   output fwd_arb_pkg::req_t                      grant,
   output logic                                   out_valid,
   output fwd_arb_pkg::src_t                      out_src,
   output fwd_arb_pkg::data_t                     out_data
);

   fwd_arb_pkg::grant_s dec;
   fwd_arb_pkg::data_t  tree_data;

   // Decode
   rr_arbiter u_arb (
      .clk   (clk),
      .rst   (rst),
      .req   (req),
      .grant (grant),
      .dec   (dec)
   );

   // Execute, TREE_H cycles through the tree
   mux_tree u_tree (
      .clk    (clk),
      .rst    (rst),
      .sel    (dec.tag),
      .ins    (in_data),
      .result (tree_data)
   );

   // Result, lines valid and index up with the word
   fwd_result u_result (
      .clk       (clk),
      .rst       (rst),
      .dec_valid (dec.valid),
      .dec_src   (dec.src),
      .tree_data (tree_data),
      .out_valid (out_valid),
      .out_src   (out_src),
      .out_data  (out_data)
   );

endmodule

//--- tb_fwd_arb.sv
`timescale 1ns/100ps

module tb_fwd_arb;

   localparam int    CLK_PERIOD   = 40;
   localparam int    RESET_CYCLES = 5;
   localparam int    MARGIN       = 20;
   localparam int    MAX_CASES    = 256;
   localparam int    MAX_TESTS    = 16;
   localparam int    SEED         = 51;
   localparam string CASES_FILE   = "fwd_arb_cases.txt";

   // One line of the cases file
   typedef struct packed {
      logic [7:0]        test;
      fwd_arb_pkg::req_t mask;
      logic              has_win;
      fwd_arb_pkg::src_t win;
   } case_s;

   // Expected output for one cycle, checked TREE_H cycles after the grant
   typedef struct packed {
      logic [7:0]         test;
      logic               last;
      logic               valid;
      fwd_arb_pkg::src_t  src;
      fwd_arb_pkg::data_t data;
   } expect_s;

   logic                                        clk;
   logic                                        rst;
   fwd_arb_pkg::req_t                           req;
   fwd_arb_pkg::data_t [fwd_arb_pkg::N_SRC-1:0] in_data;
   fwd_arb_pkg::req_t                           grant;
   logic                                        out_valid;
   fwd_arb_pkg::src_t                           out_src;
   fwd_arb_pkg::data_t                          out_data;

   case_s   cases [MAX_CASES];
   int      n_cases      = 0;
   logic    cases_loaded = 1'b0;
   logic    setup_ok     = 1'b1;
   expect_s exp_q [$];
   int      test_errs [MAX_TESTS];
   int      total_errs   = 0;
   int      tests_passed = 0;
   int      tests_failed = 0;

   fwd_arb_top uut (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .in_data   (in_data),
      .grant     (grant),
      .out_valid (out_valid),
      .out_src   (out_src),
      .out_data  (out_data)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic load_cases();
      int          fd;
      int          num;
      int          win;
      logic [7:0]  mask;
      logic [63:0] tok;
      string       line;
      fd = $fopen(CASES_FILE, "r");
      if (fd == 0) begin
         $display("Could not open cases file %s", CASES_FILE);
         setup_ok = 1'b0;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
               tok = '0;
               if ($sscanf(line, "%d %h %s", num, mask, tok) != 3 || num < 0 ||
                   num >= MAX_TESTS || n_cases >= MAX_CASES) begin
                  $display("Cases file line could not be read: %s", line);
                  setup_ok = 1'b0;
               end else begin
                  cases[n_cases].test = 8'(num);
                  cases[n_cases].mask = mask;
                  cases[n_cases].has_win = (tok != "-");
                  win = int'(tok[7:0]) - 48;
                  if (tok != "-" && (tok[63:8] != '0 || win < 0 || win >= fwd_arb_pkg::N_SRC)) begin
                     $display("Cases file names an unknown winner: %s", line);
                     setup_ok = 1'b0;
                  end
                  cases[n_cases].win = (tok == "-") ? '0 : fwd_arb_pkg::src_t'(win);
                  n_cases++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic count_error(input int test);
      test_errs[test]++;
      total_errs++;
   endtask

   task automatic close_test(input int test);
      if (test_errs[test] == 0) begin
         tests_passed++;
         $display("Test %0d done: ok", test);
      end else begin
         tests_failed++;
         $display("Test %0d done: %0d errors", test, test_errs[test]);
      end
   endtask

   task automatic check_grant(input int test, input logic exp_valid, input fwd_arb_pkg::src_t exp_src);
      fwd_arb_pkg::req_t exp_grant;
      exp_grant = fwd_arb_pkg::req_t'(1) << exp_src;
      if (!exp_valid) begin
         assert (grant == '0) else begin
            $display("Test %0d: grant %h raised while no source was requesting", test, grant);
            count_error(test);
         end
      end else begin
         assert (grant == exp_grant) else begin
            $display("MISMATCH grant: expected %h, actual %h (test %0d)", exp_grant, grant, test);
            count_error(test);
         end
      end
   endtask

   task automatic check_output(input expect_s e);
      int t;
      t = int'(e.test);
      if (e.valid) begin
         assert (out_valid) else begin
            $display("Test %0d: no output appeared for the grant to source %0d", t, e.src);
            count_error(t);
         end
         assert (out_src == e.src) else begin
            $display("MISMATCH out_src: expected %h, actual %h (test %0d)", e.src, out_src, t);
            count_error(t);
         end
         assert (out_data == e.data) else begin
            $display("MISMATCH out_data: expected %h, actual %h (test %0d)", e.data, out_data, t);
            count_error(t);
         end
      end else begin
         assert (!out_valid) else begin
            $display("Test %0d: out_valid high with no grant %0d cycles earlier", t,
                     fwd_arb_pkg::TREE_H);
            count_error(t);
         end
         assert (out_data == '0) else begin
            $display("MISMATCH out_data: expected %h, actual %h (test %0d)", 32'h0, out_data, t);
            count_error(t);
         end
      end
      if (e.last) begin
         close_test(t);
      end
   endtask

   // One clock of stimulus, then the checks at the falling edge
   task automatic drive_cycle(input int test, input fwd_arb_pkg::req_t mask, input logic exp_valid,
                              input fwd_arb_pkg::src_t exp_src, input logic last,
                              input logic hold_rst);
      fwd_arb_pkg::data_t words [fwd_arb_pkg::N_SRC];
      expect_s            entry;
      expect_s            idle;
      @(posedge clk);
      rst <= hold_rst;
      req <= mask;
      for (int s = 0; s < fwd_arb_pkg::N_SRC; s++) begin
         words[s] = $urandom();
         in_data[s] <= words[s];
      end
      @(negedge clk);
      check_grant(test, exp_valid, exp_src);
      entry.test  = 8'(test);
      entry.last  = last;
      entry.valid = exp_valid;
      entry.src   = exp_src;
      entry.data  = exp_valid ? words[exp_src] : '0;
      exp_q.push_back(entry);
      if (exp_q.size() > fwd_arb_pkg::TREE_H) begin
         check_output(exp_q.pop_front());
      end else begin
         // Pipeline still filling from reset
         idle = '0;
         idle.test = 8'(test);
         check_output(idle);
      end
   endtask

   initial begin : main
      logic last;
      void'($urandom(SEED));
      rst = 1'b1;
      req = '0;
      in_data = '0;
      for (int t = 0; t < MAX_TESTS; t++) begin
         test_errs[t] = 0;
      end
      load_cases();
      if (setup_ok && n_cases > 0) begin
         cases_loaded = 1'b1;
         // Test 0 covers the reset cycles themselves
         for (int r = 0; r < RESET_CYCLES; r++) begin
            drive_cycle(0, '0, 1'b0, '0, r == RESET_CYCLES - 1, r < RESET_CYCLES - 1);
         end
         for (int i = 0; i < n_cases; i++) begin
            last = 1'b1;
            if (i < n_cases - 1) begin
               last = (cases[i+1].test != cases[i].test);
            end
            drive_cycle(int'(cases[i].test), cases[i].mask, cases[i].has_win, cases[i].win,
                        last, 1'b0);
         end
         // Flush the last grants out of the tree
         for (int d = 0; d < fwd_arb_pkg::TREE_H; d++) begin
            drive_cycle(0, '0, 1'b0, '0, 1'b0, 1'b0);
         end
      end else begin
         $display("No usable cases were loaded from %s", CASES_FILE);
         setup_ok = 1'b0;
      end
      $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
               tests_passed, tests_failed, total_errs);
      if (setup_ok && tests_failed == 0 && total_errs == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin : watchdog
      wait (cases_loaded);
      #((n_cases + RESET_CYCLES + fwd_arb_pkg::TREE_H + MARGIN) * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d cycles",
               n_cases + RESET_CYCLES + fwd_arb_pkg::TREE_H + MARGIN);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

//--- fwd_arb_cases.txt
# test  req_mask  winner
# req_mask has one bit per source in hex, winner is the expected grant index or - for none
1 00 -
1 00 -
2 01 0
2 80 7
2 08 3
2 02 1
2 80 7
3 ff 0
3 ff 1
3 ff 2
3 ff 3
3 ff 4
3 ff 5
3 ff 6
3 ff 7
3 a5 0
3 a5 2
3 a5 5
4 81 7
4 81 0
4 18 3
4 18 4
5 00 -
5 42 6
5 00 -
5 42 1
5 00 -
5 24 2
5 00 -

//--- vlog.f
fwd_arb_pkg.sv
mux_tree_node.sv
mux_tree.sv
rr_arbiter.sv
fwd_result.sv
fwd_arb_top.sv
tb_fwd_arb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the forwarding arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_fwd_arb

verilator --binary --timing --assert -f vlog.f --top-module "$TOP" -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# The verdict comes from the log, not from the exit status alone
if grep -q "^TEST RESULT: PASS$" "$LOG"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see $LOG"
   exit 1
fi
